/* access_seq.sv */
// ========================================
// runs one or two word accesses per request
// request taken only in idle, read wins over write
// the second strobe leaves in the cycle the first
// access completes, so a split costs MEM_LAT+1 more
// ========================================
module access_seq (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_rd_en,
    input  logic                 i_wr_en,
    input  mem_types_pkg::addr_t i_addr,
    input  logic                 i_need_second,
    input  mem_types_pkg::word_t i_wdata_lo,
    input  mem_types_pkg::word_t i_wdata_hi,
    input  mem_types_pkg::mask_t i_mask_lo,
    input  mem_types_pkg::mask_t i_mask_hi,
    input  logic                 i_mem_busy,
    output logic                 o_capture,
    output logic                 o_busy,
    output logic                 o_mem_rd,
    output logic                 o_mem_wr,
    output mem_types_pkg::addr_t o_mem_addr,
    output mem_types_pkg::word_t o_mem_wdata,
    output mem_types_pkg::mask_t o_mem_mask,
    output logic                 o_load_lo,
    output logic                 o_load_hi
);
    import mem_types_pkg::*;
    import mem_ctrl_pkg::*;

    seq_state_t state;
    seq_state_t state_nx;
    logic       is_rd;      // request kind, held for the whole request
    logic       accept;
    logic       first_done; // first access completes this cycle
    logic       strobe_lo;
    logic       strobe_hi;
    addr_t      word_addr;

    assign accept     = (state == ST_IDLE) && (i_rd_en || i_wr_en);
    assign o_capture  = accept;
    assign o_busy     = (state != ST_IDLE);
    assign first_done = (state == ST_WAIT1) && !i_mem_busy;

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE: begin
                if (accept)
                    state_nx = ST_ISSUE1;
            end
            ST_ISSUE1: begin
                if (i_mem_busy)
                    state_nx = ST_WAIT1;
            end
            ST_WAIT1: begin
                if (!i_mem_busy)
                    state_nx = i_need_second ? ST_ISSUE2 : ST_DONE;
            end
            ST_ISSUE2: begin
                if (i_mem_busy)
                    state_nx = ST_WAIT2;
            end
            ST_WAIT2: begin
                if (!i_mem_busy)
                    state_nx = ST_DONE;
            end
            ST_DONE:  state_nx = ST_IDLE;
            default:  state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
            is_rd <= 1'b0;
        end else begin
            state <= state_nx;
            if (accept)
                is_rd <= i_rd_en; // read wins when both are high
        end
    end

    // memory is idle on entry to ST_ISSUE1, so this is a single pulse
    assign strobe_lo = (state == ST_ISSUE1) && !i_mem_busy;
    assign strobe_hi = first_done && i_need_second;

    assign o_mem_rd = (strobe_lo || strobe_hi) && is_rd;
    assign o_mem_wr = (strobe_lo || strobe_hi) && !is_rd;

    assign word_addr   = {i_addr[31:2], 2'b00};
    assign o_mem_addr  = strobe_hi ? word_addr + 32'd4 : word_addr;
    assign o_mem_wdata = strobe_hi ? i_wdata_hi : i_wdata_lo;
    assign o_mem_mask  = strobe_hi ? i_mask_hi : i_mask_lo;

    // read words arrive in the cycle memory busy falls
    assign o_load_lo = first_done && is_rd;
    assign o_load_hi = (state == ST_WAIT2) && !i_mem_busy && is_rd;

endmodule

/* dram_port.sv */
// ========================================
// data memory port, any size at any byte address
// levels i_rd_en/i_wr_en taken while o_busy is low
// o_busy falling marks completion
// ========================================
module dram_port (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_rd_en,
    input  logic                 i_wr_en,
    input  mem_types_pkg::addr_t i_addr,
    input  mem_types_pkg::word_t i_data,
    input  mem_types_pkg::ctrl_t i_ctrl,
    output mem_types_pkg::word_t o_data,
    output logic                 o_busy
);
    import mem_types_pkg::*;

    logic  capture;
    addr_t req_addr;
    ctrl_t req_ctrl;
    word_t wdata_lo, wdata_hi;
    mask_t mask_lo, mask_hi;
    logic  need_second;
    logic  mem_rd, mem_wr, mem_busy;
    addr_t mem_addr;
    word_t mem_wdata, mem_rdata;
    mask_t mem_mask;
    logic  load_lo, load_hi;

    store_align u_align (
        .clk(clk), .i_rst(i_rst), .i_capture(capture),
        .i_addr(i_addr), .i_data(i_data), .i_ctrl(i_ctrl),
        .o_addr(req_addr), .o_ctrl(req_ctrl),
        .o_wdata_lo(wdata_lo), .o_wdata_hi(wdata_hi),
        .o_mask_lo(mask_lo), .o_mask_hi(mask_hi),
        .o_need_second(need_second)
    );

    access_seq u_seq (
        .clk(clk), .i_rst(i_rst), .i_rd_en(i_rd_en), .i_wr_en(i_wr_en),
        .i_addr(req_addr), .i_need_second(need_second),
        .i_wdata_lo(wdata_lo), .i_wdata_hi(wdata_hi),
        .i_mask_lo(mask_lo), .i_mask_hi(mask_hi), .i_mem_busy(mem_busy),
        .o_capture(capture), .o_busy(o_busy),
        .o_mem_rd(mem_rd), .o_mem_wr(mem_wr), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .o_mem_mask(mem_mask),
        .o_load_lo(load_lo), .o_load_hi(load_hi)
    );

    load_extract u_extract (
        .clk(clk), .i_rst(i_rst), .i_load_lo(load_lo), .i_load_hi(load_hi),
        .i_mem_rdata(mem_rdata), .i_addr(req_addr), .i_ctrl(req_ctrl),
        .o_data(o_data)
    );

    word_mem u_mem (
        .clk(clk), .i_rst(i_rst), .i_rd(mem_rd), .i_wr(mem_wr),
        .i_addr(mem_addr), .i_wdata(mem_wdata), .i_mask(mem_mask),
        .o_rdata(mem_rdata), .o_busy(mem_busy)
    );

endmodule

/* dram_port_checker.sv */
// ========================================
// protocol assertions, bound into dram_port
// reaches the internal memory strobes and busy
// fails counts assertion failures for the testbench
// ========================================
module dram_port_checker (
    input logic clk,
    input logic i_rst,
    input logic i_rd_en,
    input logic i_wr_en,
    input logic i_busy,
    input logic i_mem_rd,
    input logic i_mem_wr,
    input logic i_mem_busy
);

    int fails = 0;

    // port must come out of reset idle
    a_reset_idle: assert property (@(posedge clk) i_rst |=> !i_busy)
        else begin
            fails++;
            $error("o_busy is high in the cycle after reset");
        end

    a_accept_busy: assert property (@(posedge clk) disable iff (i_rst)
        (!i_busy && (i_rd_en || i_wr_en)) |=> i_busy)
        else begin
            fails++;
            $error("accepted request did not raise o_busy");
        end

    // memory only takes a strobe while idle
    a_strobe_idle: assert property (@(posedge clk) disable iff (i_rst)
        (i_mem_rd || i_mem_wr) |-> !i_mem_busy)
        else begin
            fails++;
            $error("memory strobe while memory busy is high");
        end

endmodule

bind dram_port dram_port_checker u_checker (
    .clk(clk), .i_rst(i_rst), .i_rd_en(i_rd_en), .i_wr_en(i_wr_en),
    .i_busy(o_busy), .i_mem_rd(mem_rd), .i_mem_wr(mem_wr), .i_mem_busy(mem_busy)
);

/* dram_port_tb.sv */
// ========================================
// testbench for dram_port
// shadow byte array mirrors the 1024-byte memory
// loads of never-written bytes are not compared
// one request in flight, inputs change on negedge
// ========================================
module dram_port_tb;
    import mem_types_pkg::*;

    localparam int N_REQ       = 300; // 200 random, directed ones stay under 100
    localparam int CYC_PER_REQ = 2 * mem_ctrl_pkg::MEM_LAT + 10;
    localparam int CYC_LIMIT   = N_REQ * CYC_PER_REQ + 200;
    localparam int SPLIT_BUSY  = 2 * mem_ctrl_pkg::MEM_LAT + 4; // o_busy cycles, two words

    // one outstanding request, checked when o_busy falls
    typedef struct packed {
        logic  chk;
        ctrl_t ctrl;
        addr_t addr;
        word_t exp;
    } pend_t;

    logic  clk;
    logic  i_rst;
    logic  i_rd_en;
    logic  i_wr_en;
    addr_t i_addr;
    word_t i_data;
    ctrl_t i_ctrl;
    word_t o_data;
    logic  o_busy;

    logic [7:0] shadow [1024];
    bit         known [1024];   // byte written at least once
    pend_t      pend_q [$];
    pend_t      pend;
    logic       busy_q;
    int         errors = 0;
    int         err0 = 0;
    int         n_pass = 0;
    int         n_fail = 0;
    int         rises = 0;       // o_busy rising edges seen
    int         rise0;
    int         busy_run = 0;    // o_busy high cycles of the latest request
    int         loads_checked = 0;
    int         loads0;
    int         cycles = 0;
    int         k;
    int         s;
    int         u;
    logic       rnd_rd;
    addr_t      rnd_addr;
    addr_t      wr_addrs [$];    // random store addresses, reused by loads

    tb_clock u_clk (.o_clk(clk));

    dram_port DUT (
        .clk(clk), .i_rst(i_rst), .i_rd_en(i_rd_en), .i_wr_en(i_wr_en),
        .i_addr(i_addr), .i_data(i_data), .i_ctrl(i_ctrl),
        .o_data(o_data), .o_busy(o_busy)
    );

    function automatic int byte_count(input ctrl_t ctl);
        case (ctl[1:0])
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic ctrl_t make_ctrl(input logic [1:0] size, input logic uns);
        return {uns, size};
    endfunction

    function automatic logic all_known(input addr_t adr, input ctrl_t ctl);
        logic       ok;
        logic [9:0] idx;
        ok = 1'b1;
        for (int i = 0; i < byte_count(ctl); i++) begin
            idx = adr[9:0] + 10'(i); // wraps like the 256-word memory
            ok  = ok & known[idx];
        end
        return ok;
    endfunction

    // expected load value, little-endian bytes then extension
    function automatic word_t ref_load(input addr_t adr, input ctrl_t ctl);
        word_t      raw;
        word_t      res;
        logic [9:0] idx;
        raw = '0;
        for (int i = 0; i < byte_count(ctl); i++) begin
            idx = adr[9:0] + 10'(i);
            raw[8*i +: 8] = shadow[idx];
        end
        if (ctl[1:0] == SIZE_BYTE)
            res = ctl[2] ? {24'h0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
        else if (ctl[1:0] == SIZE_HALF)
            res = ctl[2] ? {16'h0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
        else
            res = raw;
        return res;
    endfunction

    task automatic shadow_write(input addr_t adr, input word_t dat, input ctrl_t ctl);
        logic [9:0] idx;
        for (int i = 0; i < byte_count(ctl); i++) begin
            idx = adr[9:0] + 10'(i);
            shadow[idx] = dat[8*i +: 8];
            known[idx]  = 1'b1;
        end
    endtask

    // called right after a negedge with o_busy low
    task automatic issue_request(input logic rd, input addr_t adr, input word_t dat,
                                 input ctrl_t ctl, input logic hold);
        pend_t p;
        p.chk  = rd && all_known(adr, ctl);
        p.exp  = ref_load(adr, ctl);
        p.addr = adr;
        p.ctrl = ctl;
        pend_q.push_back(p);
        if (!rd)
            shadow_write(adr, dat, ctl);
        i_rd_en = rd;
        i_wr_en = !rd;
        i_addr  = adr;
        i_data  = dat;
        i_ctrl  = ctl;
        @(negedge clk);
        assert (o_busy) else begin
            $display("request at address %h was not accepted", adr);
            errors++;
        end
        if (!hold) begin
            i_rd_en = 1'b0;
            i_wr_en = 1'b0;
        end
        while (o_busy)
            @(negedge clk);
        i_rd_en = 1'b0;
        i_wr_en = 1'b0;
    endtask

    task automatic report_test(input string name);
        while (pend_q.size() != 0)
            @(negedge clk);
        if (errors == err0) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - err0);
        end
        err0 = errors;
    endtask

    // compare process, sees pre-edge values
    always @(posedge clk) begin
        if (i_rst) begin
            busy_q = 1'b0;
        end else begin
            if (!busy_q && o_busy) begin
                rises++;
                busy_run = 1;
            end else if (o_busy) begin
                busy_run++;
            end
            if (busy_q && !o_busy) begin
                if (pend_q.size() == 0) begin
                    $display("a request finished with none outstanding at time %0t", $time);
                    errors++;
                end else begin
                    pend = pend_q.pop_front();
                    if (pend.chk) begin
                        loads_checked++;
                        assert (o_data === pend.exp) else begin
                            $display("error at %0t: load %h ctrl %b returned %h, expected %h",
                                     $time, pend.addr, pend.ctrl, o_data, pend.exp);
                            errors++;
                        end
                    end
                end
            end
            busy_q = o_busy;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYC_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYC_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(48));
        i_rst   = 1'b1;
        i_rd_en = 1'b0;
        i_wr_en = 1'b0;
        i_addr  = '0;
        i_data  = '0;
        i_ctrl  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;

        assert (!o_busy) else begin
            $display("o_busy is not low after reset");
            errors++;
        end
        for (k = 0; k < 4; k++) begin
            issue_request(1'b0, 32'h104 * k, $urandom, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
            issue_request(1'b1, 32'h104 * k, '0, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        end
        report_test("1 reset and aligned words");

        issue_request(1'b0, 32'h100, $urandom, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        issue_request(1'b0, 32'h104, $urandom, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        for (s = 0; s < 2; s++) begin
            for (k = 0; k < 4; k++) begin // SH at offset 3 spills into 0x104
                issue_request(1'b0, 32'h100 + k, $urandom, make_ctrl(2'(s), 1'b0), 1'b0);
                issue_request(1'b1, 32'h100, '0, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
                issue_request(1'b1, 32'h104, '0, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
            end
        end
        report_test("2 byte and half stores");

        issue_request(1'b0, 32'h200, $urandom, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        issue_request(1'b0, 32'h204, $urandom, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        for (k = 1; k < 4; k++) begin
            issue_request(1'b0, 32'h200 + k, $urandom, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
            issue_request(1'b1, 32'h200 + k, '0, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
            issue_request(1'b1, 32'h200, '0, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
            issue_request(1'b1, 32'h204, '0, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        end
        report_test("3 unaligned words");

        // every byte has its top bit set
        issue_request(1'b0, 32'h300, 32'h9CF0_8BA5, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        issue_request(1'b0, 32'h304, 32'hFE81_D4B6, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        for (s = 0; s < 2; s++) begin
            for (u = 0; u < 2; u++) begin
                for (k = 0; k < 4; k++)
                    issue_request(1'b1, 32'h300 + k, '0, make_ctrl(2'(s), 1'(u)), 1'b0);
            end
        end
        report_test("4 sign and zero extension");

        loads0 = loads_checked;
        for (k = 0; k < 200; k++) begin
            rnd_rd   = 1'($urandom % 2);
            rnd_addr = $urandom % 1024;
            if (rnd_rd && wr_addrs.size() != 0 && $urandom % 2 == 1)
                rnd_addr = wr_addrs[$urandom % wr_addrs.size()]; // revisit a stored address
            if (!rnd_rd)
                wr_addrs.push_back(rnd_addr);
            issue_request(rnd_rd, rnd_addr, $urandom,
                          make_ctrl(2'($urandom % 3), 1'($urandom % 2)), 1'b0);
        end
        assert (loads_checked - loads0 > 0) else begin
            $display("no random load read written bytes, so none was compared");
            errors++;
        end
        report_test("5 random traffic");
        $display("random loads compared: %0d", loads_checked - loads0);

        issue_request(1'b0, 32'h384, $urandom, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        issue_request(1'b0, 32'h388, $urandom, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        for (u = 0; u < 2; u++) begin // store then load, level held through busy
            rise0 = rises;
            issue_request(1'(u), 32'h386, 32'h5AA5_C33C, make_ctrl(SIZE_WORD, 1'b0), 1'b1);
            @(negedge clk);
            assert (!o_busy && rises - rise0 == 1 && busy_run == SPLIT_BUSY) else begin
                $display("held request was taken %0d times and kept o_busy high %0d cycles",
                         rises - rise0, busy_run);
                errors++;
            end
        end
        issue_request(1'b1, 32'h384, '0, make_ctrl(SIZE_WORD, 1'b0), 1'b0);
        issue_request(1'b1, 32'h389, '0, make_ctrl(SIZE_BYTE, 1'b1), 1'b0);
        issue_request(1'b1, 32'h387, '0, make_ctrl(SIZE_HALF, 1'b0), 1'b0);
        report_test("6 held and back-to-back requests");

        $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
                 n_pass, n_fail, DUT.u_checker.fails);
        if (n_fail == 0 && errors == 0 && DUT.u_checker.fails == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* load_extract.sv */
// ========================================
// joins the low and high read words and picks
// the addressed bytes, with LB/LH sign extension
// o_data holds until the next read returns,
// stores do not disturb it
// ========================================
module load_extract (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_load_lo,
    input  logic                 i_load_hi,
    input  mem_types_pkg::word_t i_mem_rdata,
    input  mem_types_pkg::addr_t i_addr,
    input  mem_types_pkg::ctrl_t i_ctrl,
    output mem_types_pkg::word_t o_data
);
    import mem_types_pkg::*;

    word_t       lo_q;      // word at the request address
    word_t       hi_q;      // following word, split loads only
    logic [1:0]  off_q;
    ctrl_t       ctrl_q;
    logic [63:0] shifted;
    word_t       sh;

    // offset and control latched with the first word
    always_ff @(posedge clk) begin
        if (i_rst) begin
            off_q  <= '0;
            ctrl_q <= '0;
        end else if (i_load_lo) begin
            off_q  <= i_addr[1:0];
            ctrl_q <= i_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load_lo)
            lo_q <= i_mem_rdata;
        if (i_load_hi)
            hi_q <= i_mem_rdata;
    end

    // hi_q is stale on a one-word load but never reaches the selected bits
    assign shifted = {hi_q, lo_q} >> {off_q, 3'b000};
    assign sh      = shifted[31:0];

    always_comb begin
        case (ctrl_q[1:0])
            SIZE_BYTE: o_data = ctrl_q[2] ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            SIZE_HALF: o_data = ctrl_q[2] ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default:   o_data = sh;
        endcase
    end

endmodule

/* mem_ctrl_pkg.sv */
// ========================================
// sequencer states and word memory geometry
// MEM_LAT must be at least 1
// only byte address bits 9:2 select a word
// ========================================
package mem_ctrl_pkg;

    // word access sequencer
    typedef enum logic [2:0] {
        ST_IDLE,   // waiting for a request
        ST_ISSUE1, // first strobe out, wait for busy to rise
        ST_WAIT1,  // wait for first access to finish
        ST_ISSUE2, // second strobe out, wait for busy to rise
        ST_WAIT2,  // wait for second access to finish
        ST_DONE    // one cycle before dropping the port busy
    } seq_state_t;

    localparam int MEM_WORDS = 256; // depth in 32-bit words
    localparam int MEM_LAT   = 3;   // busy cycles per access

    // derived widths
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);
    localparam int MEM_CNT_W = $clog2(MEM_LAT + 1);

endpackage

/* mem_types_pkg.sv */
// ========================================
// data, address, mask and access-control types
// byte addresses, 32-bit words, little-endian lanes
// size code 3 is handled as a word everywhere
// ========================================
package mem_types_pkg;

    // one 32-bit data word as seen by the core and the memory
    typedef logic [31:0] word_t;

    // byte address, low two bits give the lane offset
    typedef logic [31:0] addr_t;

    // byte-lane write enable, bit n covers bits 8n+7:8n
    typedef logic [3:0] mask_t;

    // access control from the core
    //   [1:0] size code
    //   [2]   unsigned load (LBU, LHU)
    typedef logic [2:0] ctrl_t;

    // size codes in ctrl_t[1:0]
    localparam logic [1:0] SIZE_BYTE = 2'd0; // LB, LBU, SB
    localparam logic [1:0] SIZE_HALF = 2'd1; // LH, LHU, SH
    localparam logic [1:0] SIZE_WORD = 2'd2; // LW, SW

endpackage

/* project.f */
mem_types_pkg.sv
mem_ctrl_pkg.sv
store_align.sv
access_seq.sv
load_extract.sv
word_mem.sv
dram_port.sv
tb_clock.sv
dram_port_checker.sv
dram_port_tb.sv

/* store_align.sv */
// ========================================
// registers a request on i_capture
// store data is cut to its size, then spread
// over the two word slots by the byte offset
// outputs hold until the next capture
// ========================================
module store_align (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_capture,
    input  mem_types_pkg::addr_t i_addr,
    input  mem_types_pkg::word_t i_data,
    input  mem_types_pkg::ctrl_t i_ctrl,
    output mem_types_pkg::addr_t o_addr,
    output mem_types_pkg::ctrl_t o_ctrl,
    output mem_types_pkg::word_t o_wdata_lo,
    output mem_types_pkg::word_t o_wdata_hi,
    output mem_types_pkg::mask_t o_mask_lo,
    output mem_types_pkg::mask_t o_mask_hi,
    output logic                 o_need_second
);
    import mem_types_pkg::*;

    word_t       data_q;     // size-truncated store data
    mask_t       base_mask;  // lanes before shifting
    logic [63:0] wide_data;
    logic [7:0]  wide_mask;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_addr <= '0;
            o_ctrl <= '0;
        end else if (i_capture) begin
            o_addr <= i_addr;
            o_ctrl <= i_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (i_capture) begin
            case (i_ctrl[1:0])
                SIZE_BYTE: data_q <= {24'h0, i_data[7:0]};
                SIZE_HALF: data_q <= {16'h0, i_data[15:0]};
                default:   data_q <= i_data;
            endcase
        end
    end

    always_comb begin
        case (o_ctrl[1:0])
            SIZE_BYTE: base_mask = 4'b0001;
            SIZE_HALF: base_mask = 4'b0011;
            default:   base_mask = 4'b1111;
        endcase
    end

    // shift across a 64-bit pair so the spill lands in the upper word
    assign wide_data = {32'h0, data_q} << {o_addr[1:0], 3'b000};
    assign wide_mask = {4'b0000, base_mask} << o_addr[1:0];

    assign o_wdata_lo = wide_data[31:0];
    assign o_wdata_hi = wide_data[63:32];
    assign o_mask_lo  = wide_mask[3:0];
    assign o_mask_hi  = wide_mask[7:4];

    // offset + size > 4 bytes
    assign o_need_second = |wide_mask[7:4];

endmodule

/* tb_clock.sv */
// ========================================
// free-running testbench clock, period 100
// starts low at time 0
// ========================================
module tb_clock (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #50 o_clk = ~o_clk; // half period

endmodule

/* word_mem.sv */
// ========================================
// word memory with lane masks and fixed latency
// strobes are ignored while busy is high
// contents are undefined until written
// read data valid when busy falls, then held
// ========================================
module word_mem (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_rd,
    input  logic                 i_wr,
    input  mem_types_pkg::addr_t i_addr,
    input  mem_types_pkg::word_t i_wdata,
    input  mem_types_pkg::mask_t i_mask,
    output mem_types_pkg::word_t o_rdata,
    output logic                 o_busy
);
    import mem_types_pkg::*;
    import mem_ctrl_pkg::*;

    word_t                mem [MEM_WORDS];
    logic [MEM_CNT_W-1:0] cnt;     // remaining busy cycles
    logic                 rd_pend; // a read is in progress
    logic [MEM_IDX_W-1:0] idx;
    logic [MEM_IDX_W-1:0] rd_idx;
    logic                 start;

    assign idx    = i_addr[MEM_IDX_W+1:2]; // upper address bits ignored
    assign start  = (i_rd || i_wr) && !o_busy;
    assign o_busy = (cnt != '0);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cnt     <= '0;
            rd_pend <= 1'b0;
        end else if (start) begin
            cnt     <= MEM_CNT_W'(MEM_LAT);
            rd_pend <= i_rd;
        end else if (o_busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == MEM_CNT_W'(1))
                rd_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            rd_idx <= idx;
        // last busy cycle, word appears as busy drops
        if (rd_pend && cnt == MEM_CNT_W'(1))
            o_rdata <= mem[rd_idx];
    end

    // write lands at the strobe, busy only models the latency
    always_ff @(posedge clk) begin
        if (i_wr && !o_busy) begin
            for (int b = 0; b < 4; b++) begin
                if (i_mask[b])
                    mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
            end
        end
    end

endmodule
